/* tdes_enc.f */
+incdir+verilog
verilog/tdes_types_pkg.sv
verilog/tdes_ctrl_pkg.sv
verilog/tdes_sequencer.sv
verilog/tdes_key_schedule.sv
verilog/tdes_round_datapath.sv
verilog/tdes_enc.sv
verif/tdes_enc_tb.sv

/* Bender.yml */
package:
  name: tdes_enc

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/tdes_types_pkg.sv
      - verilog/tdes_ctrl_pkg.sv
      - verilog/tdes_sequencer.sv
      - verilog/tdes_key_schedule.sv
      - verilog/tdes_round_datapath.sv
      - verilog/tdes_enc.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tdes_enc_tb.sv

/* verif/tdes_enc_tb.sv */
`default_nettype none

`include "tdes_defines.svh"

module tdes_enc_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import tdes_types_pkg::*;

	localparam int NUM_RUNS   = 15;
	localparam int RUN_CYCLES = 70;
	localparam int TIMEOUT_NS = 2 * NUM_RUNS * RUN_CYCLES * 20;

	localparam logic [3:0] CHK_CT  = 4'b0001;
	localparam logic [3:0] CHK_K1  = 4'b0010;
	localparam logic [3:0] CHK_K2  = 4'b0100;
	localparam logic [3:0] CHK_K3  = 4'b1000;
	localparam logic [3:0] CHK_ALL = 4'b1111;

	typedef struct packed {
		block_t   ct;
		key_set_t ek;
	} ref_t;

	logic     clk = 1'b0;
	logic     rst;
	block_t   pt;
	key_set_t keys;
	block_t   ct;
	key_set_t ek;

	logic [31:0] rng;
	int          edge_no;
	int          errors;
	int          test_err0;
	int          test_no;
	int          pass_cnt;
	int          fail_cnt;
	int          req_cnt;
	int          ack_cnt;
	string       req_label;
	logic [3:0]  req_mask;
	ref_t        req_exp;
	event        check_req;

	always #10 clk = ~clk;

	tdes_enc tdes_enc_i (
		.clk  (clk),
		.rst  (rst),
		.pt   (pt),
		.keys (keys),
		.ct   (ct),
		.ek   (ek)
	);

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Four 16-bit chunks, running XOR from the top
	function automatic half_t step_key(input half_t k);
		logic [15:0] t1;
		logic [15:0] t2;
		logic [15:0] t3;
		logic [15:0] t4;
		t1 = k[63:48] ^ {2'b00, k[13:0]};
		t2 = t1 ^ k[47:32];
		t3 = t2 ^ k[31:16];
		t4 = t3 ^ k[15:0];
		return {t1, t2, t3, t4};
	endfunction

	function automatic ref_t reference_result(input block_t p, input key_set_t k);
		ref_t  res;
		half_t l;
		half_t r;
		half_t m;
		half_t rk;
		half_t base [3];
		base[0] = k.k1;
		base[1] = k.k2;
		base[2] = k.k3;
		l = p.hi;
		r = p.lo;
		res = '0;
		for (int ps = 0; ps < `TDES_PASSES; ps++) begin
			rk = base[ps];
			for (int rd = 0; rd < `TDES_ROUNDS; rd++) begin
				m = l ^ r ^ rk;
				// Middle pass is the mirrored round
				if (ps == 1) begin
					r = l;
					l = m;
				end else begin
					l = r;
					r = m;
				end
				if (rd == `TDES_ROUNDS - 1) begin
					if (ps == 0)
						res.ek.k1 = rk;
					else if (ps == 1)
						res.ek.k2 = rk;
					else
						res.ek.k3 = rk;
				end else begin
					rk = step_key(rk);
				end
			end
		end
		res.ct.hi = l;
		res.ct.lo = r;
		return res;
	endfunction

	//////////////////////////////////////////////////
	// Comparison
	//////////////////////////////////////////////////

	always @(check_req) begin
		if (req_mask[0] && ct !== req_exp.ct) begin
			$display("error at %0t ns: %s ct got %h expected %h",
				$time, req_label, ct, req_exp.ct);
			errors++;
		end
		if (req_mask[1] && ek.k1 !== req_exp.ek.k1) begin
			$display("error at %0t ns: %s ek.k1 got %h expected %h",
				$time, req_label, ek.k1, req_exp.ek.k1);
			errors++;
		end
		if (req_mask[2] && ek.k2 !== req_exp.ek.k2) begin
			$display("error at %0t ns: %s ek.k2 got %h expected %h",
				$time, req_label, ek.k2, req_exp.ek.k2);
			errors++;
		end
		if (req_mask[3] && ek.k3 !== req_exp.ek.k3) begin
			$display("error at %0t ns: %s ek.k3 got %h expected %h",
				$time, req_label, ek.k3, req_exp.ek.k3);
			errors++;
		end
		ack_cnt++;
	end

	task automatic request_check(input string label, input logic [3:0] mask, input ref_t exp);
		req_label = label;
		req_mask = mask;
		req_exp = exp;
		req_cnt++;
		-> check_req;
		wait (ack_cnt == req_cnt);
	endtask

	task automatic end_test(input string name);
		test_no++;
		if (errors == test_err0) begin
			pass_cnt++;
			$display("test %0d %s: ok", test_no, name);
		end else begin
			fail_cnt++;
			$display("test %0d %s: %0d mismatches", test_no, name, errors - test_err0);
		end
		test_err0 = errors;
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// Five reset edges, the next edge is the load edge
	task automatic start_vector(input block_t p, input key_set_t k);
		@(posedge clk);
		rst <= 1'b1;
		pt <= p;
		keys <= k;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		edge_no = 0;
	endtask

	task automatic sample_after(input int edge_n);
		while (edge_no < edge_n) begin
			@(posedge clk);
			edge_no++;
		end
		@(negedge clk);
	endtask

	task automatic draw_half(output half_t v);
		rng = xorshift32(rng);
		v[63:32] = rng;
		rng = xorshift32(rng);
		v[31:0] = rng;
	endtask

	initial begin
		block_t   p;
		key_set_t k;
		ref_t     exp;
		ref_t     part;
		rst = 1'b1;
		pt = '0;
		keys = '0;
		rng = 32'hfc21;
		edge_no = 0;
		errors = 0;
		test_err0 = 0;
		test_no = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		req_cnt = 0;
		ack_cnt = 0;

		// All zero
		start_vector('0, '0);
		sample_after(49);
		request_check("zero", CHK_ALL, reference_result('0, '0));
		end_test("all zero");

		for (int i = 0; i < 4; i++) begin
			case (i)
				0: begin
					p = {64'h0123456789abcdef, 64'hfedcba9876543210};
					k = {64'h133457799bbcdff1, 64'h0e329232ea6d0d73, 64'h2b7e151628aed2a6};
				end
				1: begin
					p = {64'hffffffffffffffff, 64'h0000000000000000};
					k = {64'h8000000000000001, 64'h00000000ffffffff, 64'h5555aaaa5555aaaa};
				end
				2: begin
					p = {{16{4'ha}}, {16{4'h5}}};
					k = {64'h0000000000003fff, 64'hc000000000000000, 64'h0123012301230123};
				end
				default: begin
					p = {64'hdeadbeefcafef00d, 64'h0102030405060708};
					k = {64'h1111111111111111, 64'h2222222222222222, 64'h3333333333333333};
				end
			endcase
			start_vector(p, k);
			sample_after(49);
			request_check($sformatf("directed %0d", i), CHK_CT, reference_result(p, k));
		end
		end_test("directed");

		for (int i = 0; i < 8; i++) begin
			draw_half(p.hi);
			draw_half(p.lo);
			draw_half(k.k1);
			draw_half(k.k2);
			draw_half(k.k3);
			start_vector(p, k);
			sample_after(49);
			request_check($sformatf("random %0d", i), CHK_ALL, reference_result(p, k));
		end
		end_test("random");

		// Pass boundaries, later ek fields still clear
		p = {64'h0f0f0f0f0f0f0f0f, 64'h3c3c3c3c3c3c3c3c};
		k = {64'h0123456789abcdef, 64'h89abcdef01234567, 64'hfedcba9876543210};
		exp = reference_result(p, k);
		start_vector(p, k);
		sample_after(17);
		part = exp;
		part.ek.k2 = '0;
		part.ek.k3 = '0;
		request_check("after pass 1", CHK_K1 | CHK_K2 | CHK_K3, part);
		sample_after(33);
		part.ek.k2 = exp.ek.k2;
		request_check("after pass 2", CHK_K1 | CHK_K2 | CHK_K3, part);
		sample_after(49);
		request_check("after pass 3", CHK_ALL, exp);
		end_test("pass boundary");

		// Reset value, late pt change, hold after completion
		p = {64'h0011223344556677, 64'h8899aabbccddeeff};
		k = {64'hc0ffee00c0ffee00, 64'h1234567812345678, 64'habcdef01abcdef01};
		exp = reference_result(p, k);
		part = '0;
		start_vector(p, k);
		sample_after(0);
		request_check("reset", CHK_CT, part);
		for (int e = 1; e <= 48; e++) begin
			while (edge_no < e) begin
				@(posedge clk);
				edge_no++;
			end
			if (e == 1)
				pt <= ~p;
			@(negedge clk);
			request_check($sformatf("edge %0d", e), CHK_CT, part);
		end
		sample_after(49);
		request_check("completion", CHK_ALL, exp);
		for (int c = 1; c <= 10; c++) begin
			sample_after(49 + c);
			request_check($sformatf("hold %0d", c), CHK_ALL, exp);
		end
		end_test("reset and hold");

		$display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
		if (errors == 0 && fail_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the run hung after %0d ns without finishing its tests", TIMEOUT_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/tdes_enc.sv */
`default_nettype none

module tdes_enc (
	input  wire                      clk,
	input  wire                      rst,
	input  tdes_types_pkg::block_t   pt,
	input  tdes_types_pkg::key_set_t keys,
	output tdes_types_pkg::block_t   ct,
	output tdes_types_pkg::key_set_t ek
);

	import tdes_types_pkg::*;
	import tdes_ctrl_pkg::*;

	seq_ctrl_t ctrl;
	half_t     round_key;

	tdes_sequencer sequencer_i (
		.clk  (clk),
		.rst  (rst),
		.ctrl (ctrl)
	);

	tdes_key_schedule key_schedule_i (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrl),
		.keys      (keys),
		.round_key (round_key),
		.ek        (ek)
	);

	tdes_round_datapath round_datapath_i (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrl),
		.pt        (pt),
		.round_key (round_key),
		.ct        (ct)
	);

endmodule

`default_nettype wire

/* verilog/tdes_round_datapath.sv */
`default_nettype none

module tdes_round_datapath (
	input  wire                      clk,
	input  wire                      rst,
	input  tdes_ctrl_pkg::seq_ctrl_t ctrl,
	input  tdes_types_pkg::block_t   pt,
	input  tdes_types_pkg::half_t    round_key,
	output tdes_types_pkg::block_t   ct
);

	import tdes_types_pkg::*;
	import tdes_ctrl_pkg::*;

	half_t  l_q;
	half_t  r_q;
	half_t  mix;
	block_t rnd;
	logic   final_round;

	assign mix = l_q ^ r_q ^ round_key;
	assign final_round = ctrl.run && ctrl.last_round && (ctrl.pass == PASS_ENC3);

	//////////////////////////////////////////////////
	// One round per clock
	//////////////////////////////////////////////////

	// Decrypt pass runs the mirrored round
	always_comb begin
		if (ctrl.pass == PASS_DEC2) begin
			rnd.hi = mix;
			rnd.lo = l_q;
		end else begin
			rnd.hi = r_q;
			rnd.lo = mix;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.load) begin
			l_q <= pt.hi;
			r_q <= pt.lo;
		end else if (ctrl.run) begin
			l_q <= rnd.hi;
			r_q <= rnd.lo;
		end
	end

	// Result of round 48
	always_ff @(posedge clk) begin
		if (rst)
			ct <= '0;
		else if (final_round)
			ct <= rnd;
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// ct moves only as the sequencer leaves the run phase
	ct_on_final_round: assert property (@(posedge clk) disable iff (rst)
		!$stable(ct) |-> $fell(ctrl.run));

endmodule

`default_nettype wire

/* verilog/tdes_key_schedule.sv */
`default_nettype none

module tdes_key_schedule (
	input  wire                      clk,
	input  wire                      rst,
	input  tdes_ctrl_pkg::seq_ctrl_t ctrl,
	input  tdes_types_pkg::key_set_t keys,
	output tdes_types_pkg::half_t    round_key,
	output tdes_types_pkg::key_set_t ek
);

	import tdes_types_pkg::*;
	import tdes_ctrl_pkg::*;

	half_t key_q;
	half_t next_base;

	// Base key of the pass that follows the current one
	always_comb begin
		case (ctrl.pass)
			PASS_ENC1: next_base = keys.k2;
			PASS_DEC2: next_base = keys.k3;
			default:   next_base = key_q;
		endcase
	end

	//////////////////////////////////////////////////
	// Current round key
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (ctrl.load) begin
			key_q <= keys.k1;
		end else if (ctrl.run) begin
			if (ctrl.last_round)
				key_q <= next_base;
			else
				key_q <= key_step(key_q);
		end
	end

	assign round_key = key_q;

	// Key used in round 16 of each pass
	always_ff @(posedge clk) begin
		if (rst) begin
			ek <= '0;
		end else if (ctrl.run && ctrl.last_round) begin
			case (ctrl.pass)
				PASS_ENC1: ek.k1 <= key_q;
				PASS_DEC2: ek.k2 <= key_q;
				default:   ek.k3 <= key_q;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// An ek update lines up with the end of a pass
	ek_on_last_round: assert property (@(posedge clk) disable iff (rst)
		!$stable(ek) |-> (ctrl.pass != $past(ctrl.pass)) || !ctrl.run);

endmodule

`default_nettype wire

/* verilog/tdes_sequencer.sv */
`default_nettype none

`include "tdes_defines.svh"

module tdes_sequencer (
	input  wire                     clk,
	input  wire                     rst,
	output tdes_ctrl_pkg::seq_ctrl_t ctrl
);

	import tdes_ctrl_pkg::*;

	localparam int ROUND_W = $clog2(`TDES_ROUNDS);
	localparam logic [ROUND_W-1:0] ROUND_LAST = ROUND_W'(`TDES_ROUNDS - 1);
	localparam pass_t PASS_LAST = pass_t'(`TDES_PASSES - 1);

	typedef enum logic [1:0] {
		PH_LOAD,
		PH_RUN,
		PH_DONE
	} phase_t;

	phase_t             phase;
	logic [ROUND_W-1:0] round_cnt;
	pass_t              pass_q;
	logic               at_last;

	assign at_last = (round_cnt == ROUND_LAST);

	//////////////////////////////////////////////////
	// Phase, round and pass counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			phase     <= PH_LOAD;
			round_cnt <= '0;
			pass_q    <= PASS_ENC1;
		end else begin
			case (phase)
				PH_LOAD: begin
					phase     <= PH_RUN;
					round_cnt <= '0;
					pass_q    <= PASS_ENC1;
				end
				PH_RUN: begin
					if (at_last) begin
						round_cnt <= '0;
						// Park once the final pass is through
						if (pass_q == PASS_LAST)
							phase <= PH_DONE;
						else
							pass_q <= pass_t'(pass_q + 2'd1);
					end else begin
						round_cnt <= round_cnt + 1'b1;
					end
				end
				default: begin
					phase <= PH_DONE;
				end
			endcase
		end
	end

	always_comb begin
		ctrl.load       = (phase == PH_LOAD);
		ctrl.run        = (phase == PH_RUN);
		ctrl.pass       = pass_q;
		ctrl.last_round = (phase == PH_RUN) && at_last;
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Each pass spans exactly 16 rounds
	pass_len: assert property (@(posedge clk) disable iff (rst)
		ctrl.last_round |-> $past(ctrl.load || ctrl.last_round, `TDES_ROUNDS));

	run_ends_after_enc3: assert property (@(posedge clk) disable iff (rst)
		$fell(ctrl.run) |-> $past(ctrl.last_round && (ctrl.pass == PASS_ENC3)));

endmodule

`default_nettype wire

/* verilog/tdes_ctrl_pkg.sv */
`default_nettype none

package tdes_ctrl_pkg;

	// Order matters, the sequencer steps through it
	typedef enum logic [1:0] {
		PASS_ENC1,
		PASS_DEC2,
		PASS_ENC3
	} pass_t;

	//////////////////////////////////////////////////
	// Sequencer to datapath and key schedule
	//////////////////////////////////////////////////

	typedef struct packed {
		logic  load;
		logic  run;
		pass_t pass;
		logic  last_round;
	} seq_ctrl_t;

endpackage

`default_nettype wire

/* verilog/tdes_types_pkg.sv */
`default_nettype none

`include "tdes_defines.svh"

package tdes_types_pkg;

	localparam int HALF_W = `TDES_HALF_W;
	localparam int CW = `TDES_CHUNK_W;

	typedef logic [HALF_W-1:0] half_t;

	// hi is the left half, lo the right half
	typedef struct packed {
		half_t hi;
		half_t lo;
	} block_t;

	typedef struct packed {
		half_t k1;
		half_t k2;
		half_t k3;
	} key_set_t;

	//////////////////////////////////////////////////
	// Key step
	//////////////////////////////////////////////////

	// Chained XOR of the chunks, top chunk folded with the low key bits
	function automatic half_t key_step(input half_t key);
		logic [CW-1:0] t1;
		logic [CW-1:0] t2;
		logic [CW-1:0] t3;
		logic [CW-1:0] t4;
		t1 = key[4*CW-1 -: CW] ^ CW'(key[CW-3:0]);
		t2 = t1 ^ key[3*CW-1 -: CW];
		t3 = t2 ^ key[2*CW-1 -: CW];
		t4 = t3 ^ key[CW-1:0];
		return {t1, t2, t3, t4};
	endfunction

endpackage

`default_nettype wire

/* verilog/tdes_defines.svh */
`ifndef TDES_DEFINES_SVH
`define TDES_DEFINES_SVH

//////////////////////////////////////////////////
// Block geometry
//////////////////////////////////////////////////

// One block half, also the key width
`define TDES_HALF_W 64

// Rounds in one pass
`define TDES_ROUNDS 16

// Encrypt, decrypt, encrypt
`define TDES_PASSES 3

// Key step works on four chunks of this width
`define TDES_CHUNK_W 16

`endif
